//--- common/cache_pkg.sv
`default_nettype none

package cache_pkg;

	// processor data word
	typedef logic [15:0] word_t;

	// byte address, bit 0 unused since only whole words move
	typedef logic [15:0] addr_t;

	// address fields
	// tag is addr[15:11], index addr[10:4], word offset addr[3:1]
	typedef logic [4:0] tag_t;
	typedef logic [6:0] index_t;
	typedef logic [2:0] offset_t;

	// processor request, held on the port while stall is high
	typedef struct packed {
		logic  op;
		logic  write;
		addr_t addr;
		word_t wdata;
	} cache_req_t;

	// one tag array entry
	typedef struct packed {
		logic valid;
		tag_t tag;
	} meta_t;

	// main memory request, one per cycle
	typedef struct packed {
		logic  en;
		logic  wr;
		addr_t addr;
		word_t wdata;
	} mem_req_t;

	// line fill FSM
	typedef enum logic [1:0] {
		IDLE,
		FETCH,
		DRAIN,
		TAG_WR
	} fill_state_t;

endpackage

`default_nettype wire

//--- cache/cache_lookup.sv
`timescale 1ns/1ps
`default_nettype none

module cache_lookup (
	input  wire                clk,
	input  wire                rst_n,
	input  cache_pkg::addr_t   addr,
	input  wire                meta_we,
	input  cache_pkg::meta_t   meta_in,
	output cache_pkg::index_t  index,
	output cache_pkg::offset_t offset,
	output logic               hit
);
	import cache_pkg::*;

	localparam int LINES = 2 ** $bits(index_t);

	tag_t  tag;
	meta_t entry;

	// one entry per line
	meta_t meta [LINES];

	// field split
	// addr[0] is the byte bit and is ignored
	assign tag = addr[15:11];
	assign index = addr[10:4];
	assign offset = addr[3:1];

	// valid bits must clear on reset
	// tags cleared too, whole entry is small
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < LINES; i++) begin
				meta[i] <= '0;
			end
		end else if (meta_we) begin
			// request is held during a fill
			// so index still names the line being filled
			meta[index] <= meta_in;
		end
	end

	// asynchronous read of the selected entry
	assign entry = meta[index];

	// hit on a valid entry with matching tag
	assign hit = entry.valid & (entry.tag == tag);

endmodule

`default_nettype wire

//--- cache/cache_fill.sv
`timescale 1ns/1ps
`default_nettype none

module cache_fill #(
	parameter int MEM_LATENCY = 4
) (
	input  wire                  clk,
	input  wire                  rst_n,
	input  wire                  miss,
	input  cache_pkg::addr_t     miss_addr,
	input  wire                  data_valid,
	output logic                 busy,
	output cache_pkg::offset_t   fill_offset,
	output cache_pkg::mem_req_t  mem_req,
	output logic                 data_we,
	output logic                 meta_we,
	output cache_pkg::meta_t     meta_out
);
	import cache_pkg::*;

	// reads in flight never exceed the memory latency
	localparam int OUT_W = $clog2(MEM_LATENCY + 1);

	fill_state_t      state;
	fill_state_t      state_next;
	offset_t          issue_cnt;
	offset_t          recv_cnt;
	logic [OUT_W-1:0] outstanding;
	logic             issue;

	assign busy = (state != IDLE);

	// one read per cycle while fetching
	assign issue = (state == FETCH);

	// line base plus word number
	assign mem_req.en = issue;
	assign mem_req.wr = 1'b0;
	assign mem_req.addr = {miss_addr[15:4], issue_cnt, 1'b0};
	assign mem_req.wdata = '0;

	// returned words land in order
	assign data_we = busy & data_valid;
	assign fill_offset = recv_cnt;

	// tag goes in after the whole line is present
	assign meta_we = (state == TAG_WR);
	assign meta_out.valid = 1'b1;
	assign meta_out.tag = miss_addr[15:11];

	always_comb begin
		state_next = state;
		case (state)
			IDLE:    if (miss) state_next = FETCH;
			FETCH:   if (issue_cnt == offset_t'(7)) state_next = DRAIN;
			// last data back when only one read remains in flight
			DRAIN:   if (data_valid && outstanding == OUT_W'(1)) state_next = TAG_WR;
			TAG_WR:  state_next = IDLE;
			default: state_next = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
			issue_cnt <= '0;
			recv_cnt <= '0;
			outstanding <= '0;
		end else begin
			state <= state_next;
			// counters start fresh for each fill
			if (state == IDLE) begin
				issue_cnt <= '0;
				recv_cnt <= '0;
			end else begin
				if (issue) issue_cnt <= issue_cnt + offset_t'(1);
				if (data_we) recv_cnt <= recv_cnt + offset_t'(1);
			end
			// issue and return may coincide
			case ({issue, data_we})
				2'b10:   outstanding <= outstanding + OUT_W'(1);
				2'b01:   outstanding <= outstanding - OUT_W'(1);
				default: outstanding <= outstanding;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- cache/cache_data_array.sv
`timescale 1ns/1ps
`default_nettype none

module cache_data_array (
	input  wire                clk,
	input  cache_pkg::index_t  index,
	input  cache_pkg::offset_t offset,
	input  wire                we,
	input  cache_pkg::word_t   wdata,
	output cache_pkg::word_t   rdata
);
	import cache_pkg::*;

	// 128 lines of 8 words
	localparam int DEPTH = 2 ** ($bits(index_t) + $bits(offset_t));

	logic [$bits(index_t)+$bits(offset_t)-1:0] word_addr;

	// word storage, contents only meaningful behind a valid tag
	word_t mem [DEPTH];

	// line number high, word number low
	assign word_addr = {index, offset};

	// single write port
	always_ff @(posedge clk) begin
		if (we) begin
			mem[word_addr] <= wdata;
		end
	end

	// read hit data same cycle
	assign rdata = mem[word_addr];

endmodule

`default_nettype wire

//--- logic/mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module mem_model #(
	parameter int MEM_LATENCY = 4,
	parameter int MEM_WORDS = 32768
) (
	input  wire                 clk,
	input  wire                 rst_n,
	input  cache_pkg::mem_req_t mem_req,
	output cache_pkg::word_t    rd_data,
	output logic                data_valid
);
	import cache_pkg::*;

	localparam int AW = $clog2(MEM_WORDS);

	logic [AW-1:0] word_addr;
	logic          rd_en;

	// word storage
	word_t mem [MEM_WORDS];

	// read return pipeline
	word_t                  pipe_data [MEM_LATENCY];
	logic [MEM_LATENCY-1:0] pipe_valid;

	// byte address to word address
	assign word_addr = mem_req.addr[AW:1];
	assign rd_en = mem_req.en & ~mem_req.wr;

	// memory starts out all zero
	initial begin
		for (int i = 0; i < MEM_WORDS; i++) begin
			mem[i] = '0;
		end
	end

	// writes land at the edge
	always_ff @(posedge clk) begin
		if (mem_req.en && mem_req.wr) begin
			mem[word_addr] <= mem_req.wdata;
		end
	end

	// data shifts every cycle, new read enters stage 0
	always_ff @(posedge clk) begin
		pipe_data[0] <= mem[word_addr];
		for (int i = 1; i < MEM_LATENCY; i++) begin
			pipe_data[i] <= pipe_data[i-1];
		end
	end

	// valid flag travels alongside the data
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pipe_valid <= '0;
		end else begin
			pipe_valid <= {pipe_valid[MEM_LATENCY-2:0], rd_en};
		end
	end

	// output after MEM_LATENCY cycles
	assign rd_data = pipe_data[MEM_LATENCY-1];
	assign data_valid = pipe_valid[MEM_LATENCY-1];

endmodule

`default_nettype wire

//--- cache/cache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl #(
	parameter int MEM_LATENCY = 4,
	parameter int MEM_WORDS = 32768
) (
	input  wire                  clk,
	input  wire                  rst_n,
	input  cache_pkg::cache_req_t req,
	output cache_pkg::word_t      rdata,
	output logic                  stall
);
	import cache_pkg::*;

	index_t   index;
	offset_t  req_offset;
	offset_t  fill_offset;
	offset_t  offset;
	logic     hit;
	logic     miss;
	logic     busy;
	logic     data_we;
	logic     meta_we;
	meta_t    fill_meta;
	logic     cpu_wr_hit;
	logic     array_we;
	word_t    array_wdata;
	mem_req_t fill_mem_req;
	mem_req_t cpu_mem_req;
	mem_req_t mem_req;
	word_t    mem_rdata;
	logic     data_valid;
	logic     stall_now;
	logic     extra_stall;

	// miss when a valid request finds no matching valid line
	assign miss = req.op & ~hit;

	// processor write hit updates the line, never during a fill
	assign cpu_wr_hit = req.op & req.write & hit & ~busy;

	// fill owns the word select while busy
	assign offset = busy ? fill_offset : req_offset;

	// only writes go to memory from the port
	// reads are served by the array or by a fill
	assign cpu_mem_req.en = req.op & req.write;
	assign cpu_mem_req.wr = req.write;
	assign cpu_mem_req.addr = req.addr;
	assign cpu_mem_req.wdata = req.wdata;

	assign mem_req = busy ? fill_mem_req : cpu_mem_req;

	// array written by returning fill data or by a write hit
	assign array_we = data_we | cpu_wr_hit;
	assign array_wdata = data_we ? mem_rdata : req.wdata;

	cache_lookup u_lookup (
		.clk     (clk),
		.rst_n   (rst_n),
		.addr    (req.addr),
		.meta_we (meta_we),
		.meta_in (fill_meta),
		.index   (index),
		.offset  (req_offset),
		.hit     (hit)
	);

	cache_fill #(
		.MEM_LATENCY (MEM_LATENCY)
	) u_fill (
		.clk         (clk),
		.rst_n       (rst_n),
		.miss        (miss),
		.miss_addr   (req.addr),
		.data_valid  (data_valid),
		.busy        (busy),
		.fill_offset (fill_offset),
		.mem_req     (fill_mem_req),
		.data_we     (data_we),
		.meta_we     (meta_we),
		.meta_out    (fill_meta)
	);

	cache_data_array u_data (
		.clk    (clk),
		.index  (index),
		.offset (offset),
		.we     (array_we),
		.wdata  (array_wdata),
		.rdata  (rdata)
	);

	mem_model #(
		.MEM_LATENCY (MEM_LATENCY),
		.MEM_WORDS   (MEM_WORDS)
	) u_mem (
		.clk        (clk),
		.rst_n      (rst_n),
		.mem_req    (mem_req),
		.rd_data    (mem_rdata),
		.data_valid (data_valid)
	);

	// stall holds one cycle past the fill so the tag write settles
	assign stall_now = busy | miss;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			extra_stall <= 1'b0;
		end else begin
			extra_stall <= stall_now;
		end
	end

	assign stall = stall_now | extra_stall;

endmodule

`default_nettype wire

//--- verif/tb_cache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cache;
	import cache_pkg::*;

	localparam int MEM_LATENCY = 4;
	// longest stall a single request may see
	localparam int STALL_LIMIT = 8 + MEM_LATENCY + 3;
	// about 60 requests of up to 15 cycles plus reset and margin
	localparam int MAX_CYCLES = 4000;

	logic       clk;
	logic       rst_n;
	cache_req_t req;
	word_t      rdata;
	logic       stall;

	// expected memory contents, keyed by word-aligned address
	word_t ref_mem [addr_t];

	int     seed = 32'h8c65;
	int     passes = 0;
	int     fails = 0;
	int     test_fails = 0;
	int     cycles = 0;
	int     stall_cycles;
	word_t  last_rdata;
	addr_t  a;
	addr_t  b;
	word_t  d;
	addr_t  addrs [8];
	word_t  datas [8];

	cache_ctrl DUT (
		.clk   (clk),
		.rst_n (rst_n),
		.req   (req),
		.rdata (rdata),
		.stall (stall)
	);

	always #50 clk = ~clk;

	// run limit
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	// idle port never stalls
	assert property (@(posedge clk) disable iff (!rst_n) !req.op |-> !stall)
		else begin
			$display("FAIL %0t: stall high with no request on the port", $time);
			fails++;
		end

	function automatic word_t ref_read(input addr_t addr);
		addr_t key;
		key = {addr[15:1], 1'b0};
		if (ref_mem.exists(key)) begin
			return ref_mem[key];
		end
		return '0;
	endfunction

	task automatic rand_word(output word_t w);
		logic [31:0] r;
		r = $random(seed);
		w = r[15:0];
	endtask

	// drive at the falling edge and hold until stall is seen low
	task automatic issue(input logic write, input addr_t addr, input word_t wdata);
		req.op = 1'b1;
		req.write = write;
		req.addr = addr;
		req.wdata = wdata;
		stall_cycles = 0;
		@(negedge clk);
		while (stall) begin
			stall_cycles++;
			@(negedge clk);
		end
		last_rdata = rdata;
		assert (stall_cycles <= STALL_LIMIT) passes++;
		else begin
			$display("FAIL %0t: stall held %0d cycles at %h", $time, stall_cycles, addr);
			fails++;
		end
		// memory follows every write through the cache
		if (write) begin
			ref_mem[{addr[15:1], 1'b0}] = wdata;
		end
	endtask

	task automatic read_check(input addr_t addr, input string what);
		word_t expected;
		expected = ref_read(addr);
		issue(1'b0, addr, 16'h0000);
		assert (last_rdata == expected) passes++;
		else begin
			$display("FAIL %0t: %s read %h got %h expected %h",
				$time, what, addr, last_rdata, expected);
			fails++;
		end
	endtask

	task automatic expect_stall(input logic raised, input string what);
		assert ((stall_cycles > 0) == raised) passes++;
		else begin
			$display("FAIL %0t: %s saw %0d stall cycles", $time, what, stall_cycles);
			fails++;
		end
	endtask

	task automatic end_test(input string name);
		$display("test %s: %s, %0d failed checks", name,
			(fails == test_fails) ? "ok" : "bad", fails - test_fails);
		test_fails = fails;
	endtask

	// drop the request for one cycle
	task automatic go_idle();
		req = '0;
		@(negedge clk);
	endtask

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		req = '0;
		repeat (16) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);

		// reset state and cold misses
		assert (!stall) passes++;
		else begin
			$display("FAIL %0t: stall high after reset", $time);
			fails++;
		end
		rand_word(a);
		a[0] = 1'b0;
		read_check(a, "cold");
		expect_stall(1'b1, "cold miss");
		read_check(a, "cold again");
		expect_stall(1'b0, "hit after fill");
		end_test("reset");

		// random write then read back
		for (int i = 0; i < 8; i++) begin
			rand_word(addrs[i]);
			addrs[i][0] = 1'b0;
			rand_word(datas[i]);
			issue(1'b1, addrs[i], datas[i]);
		end
		for (int i = 0; i < 8; i++) begin
			read_check(addrs[i], "readback");
		end
		end_test("write_read");

		// whole line arrives with one fill
		rand_word(a);
		a = {a[15:4], 4'h0};
		read_check(a, "line word 0");
		for (int w = 1; w < 8; w++) begin
			read_check({a[15:4], w[2:0], 1'b0}, "line word");
			expect_stall(1'b0, "same line");
		end
		end_test("line_fill");

		// same index with tags that differ in the top bit
		rand_word(a);
		a[0] = 1'b0;
		b = a ^ 16'h8000;
		rand_word(d);
		issue(1'b1, a, d);
		rand_word(d);
		issue(1'b1, b, d);
		for (int i = 0; i < 4; i++) begin
			read_check(a, "conflict a");
			expect_stall(1'b1, "evict a");
			read_check(b, "conflict b");
			expect_stall(1'b1, "evict b");
		end
		end_test("conflict");

		// write hit stays unstalled
		rand_word(a);
		a[0] = 1'b0;
		read_check(a, "prefetch");
		rand_word(d);
		issue(1'b1, a, d);
		expect_stall(1'b0, "write hit");
		read_check(a, "after write hit");
		expect_stall(1'b0, "read after write hit");
		// refill after eviction must bring the hit data back from memory
		read_check(a ^ 16'h8000, "evictor");
		expect_stall(1'b1, "evict written line");
		read_check(a, "refill after write hit");
		expect_stall(1'b1, "refill written line");
		end_test("write_hit");

		// mixed traffic with the stall bound checked in issue
		for (int i = 0; i < 16; i++) begin
			rand_word(a);
			a[0] = 1'b0;
			rand_word(d);
			if (d[0]) begin
				issue(1'b1, a, d);
			end else begin
				read_check(a, "mixed");
			end
		end
		go_idle();
		end_test("stall_bound");

		$display("checks passed %0d, failed %0d", passes, fails);
		if (fails == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
common/cache_pkg.sv
cache/cache_lookup.sv
cache/cache_fill.sv
cache/cache_data_array.sv
logic/mem_model.sv
cache/cache_ctrl.sv
verif/tb_cache.sv

//--- Makefile
TOP = tb_cache

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f filelist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^NO ERRORS$$"

clean:
	rm -rf obj_dir
